/* bench/tk1_model.svh */
// Reference model functions for the tk1 bench, included inside the testbench module
`ifndef TK1_MODEL_SVH
`define TK1_MODEL_SVH

// Offset size of an MMIO block, zero for unassigned block numbers
function automatic int mmio_block_bits(logic [5:0] block);
  case (block)
    `TK1_MMIO_TRNG_ID:    return `TK1_MMIO_TRNG_BITS;
    `TK1_MMIO_TIMER_ID:   return `TK1_MMIO_TIMER_BITS;
    `TK1_MMIO_UDS_ID:     return `TK1_MMIO_UDS_BITS;
    `TK1_MMIO_UART_ID:    return `TK1_MMIO_UART_BITS;
    `TK1_MMIO_TOUCH_ID:   return `TK1_MMIO_TOUCH_BITS;
    `TK1_MMIO_FW_RAM_ID:  return `TK1_MMIO_FW_RAM_BITS;
    `TK1_MMIO_SYSCALL_ID: return `TK1_MMIO_SYSCALL_BITS;
    `TK1_MMIO_TK1_ID:     return `TK1_MMIO_TK1_BITS;
    default:              return 0;
  endcase
endfunction

// Address map rule, checked on every valid access
function automatic bit map_violation(word_t addr);
  int bits;
  bits = mmio_block_bits(addr[29:24]);
  case (addr[31:30])
    2'b00:   return addr[29:0] >= (30'd1 << `TK1_ROM_ADDR_BITS);
    2'b01:   return addr[29:0] >= (30'd1 << `TK1_RAM_ADDR_BITS);
    2'b10:   return 1'b1;
    default: return (bits == 0) || (addr[23:0] >= (24'd1 << bits));
  endcase
endfunction

// Extra rules for instruction fetches
function automatic bit exec_violation(word_t addr, bit app_mode, bit win_en,
                                      word_t win_first, word_t win_last);
  bit in_fw_ram;
  bit in_window;
  in_fw_ram = (addr >= `TK1_FW_RAM_FIRST) && (addr <= `TK1_FW_RAM_LAST);
  in_window = win_en && (addr >= win_first) && (addr <= win_last);
  return in_fw_ram || in_window || (app_mode && (addr <= `TK1_FW_ROM_LAST));
endfunction

// Stored value of a register after a write, old value when the write is refused
function automatic word_t reg_after_write(reg_addr_t addr, word_t old, word_t wdata,
                                          bit app_mode, bit win_en);
  case (addr)
    `TK1_ADDR_LED:       return {29'h0, wdata[2:0]};
    `TK1_ADDR_GPIO:      return {28'h0, wdata[3:2], 2'b00};
    `TK1_ADDR_APP_START: return app_mode ? old : wdata;
    `TK1_ADDR_APP_SIZE:  return app_mode ? old : wdata;
    `TK1_ADDR_MON_CTRL:  return 32'h1;
    `TK1_ADDR_MON_FIRST: return win_en ? old : wdata;
    `TK1_ADDR_MON_LAST:  return win_en ? old : wdata;
    default: begin
      if ((addr >= `TK1_ADDR_CDI_FIRST) && (addr <= `TK1_ADDR_CDI_LAST)) begin
        return app_mode ? old : wdata;
      end
      return old;
    end
  endcase
endfunction

// Expected read data, unmapped and write-only registers read zero
function automatic word_t reg_read_value(reg_addr_t addr, word_t stored, logic [1:0] gpio);
  case (addr)
    `TK1_ADDR_NAME0:     return "tk1 ";
    `TK1_ADDR_NAME1:     return "mkdf";
    `TK1_ADDR_VERSION:   return 32'd6;
    `TK1_ADDR_LED:       return stored;
    `TK1_ADDR_GPIO:      return stored | {30'h0, gpio};
    `TK1_ADDR_APP_START: return stored;
    `TK1_ADDR_APP_SIZE:  return stored;
    default: return ((addr >= `TK1_ADDR_CDI_FIRST) && (addr <= `TK1_ADDR_CDI_LAST)) ?
                    stored : 32'h0;
  endcase
endfunction

`endif

/* bench/tb_tk1.sv */
// Testbench for the tk1 core driving APB and CPU bus with seeded random stimulus against a model
`timescale 1ns/1ps
`default_nettype none

`include "tk1_config.svh"

module tb_tk1;
  import tk1_pkg::*;

  localparam word_t APP_SIZE_INIT  = 32'h0002_0000;
  localparam int    TIMEOUT_CYCLES = 16;
  localparam logic [5:0] MMIO_IDS [0:3] = '{`TK1_MMIO_UDS_ID, `TK1_MMIO_FW_RAM_ID,
                                            `TK1_MMIO_SYSCALL_ID, `TK1_MMIO_TK1_ID};

  logic       clk = 1'b0;
  logic       reset_n;
  logic       psel;
  logic       penable;
  logic       pwrite;
  reg_addr_t  paddr;
  word_t      pwdata;
  word_t      prdata;
  logic       pready;
  logic       cpu_valid;
  logic       cpu_instr;
  logic       cpu_trap;
  logic       syscall;
  word_t      cpu_addr;
  logic       force_trap;
  logic       fw_startup_done;
  logic       app_mode;
  logic [1:0] gpio_in;
  logic [1:0] gpio_out;
  logic       led_r;
  logic       led_g;
  logic       led_b;

  // Model state
  word_t shadow [0:255];
  bit    model_trap;
  bit    model_fw_done;
  int    checks;
  int    errors;
  int    timeouts;

  `include "tk1_model.svh"

  tk1 #(
    .app_size_init (APP_SIZE_INIT),
    .blink_width   (4)
  ) dut0 (
    .clk (clk), .reset_n (reset_n),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .prdata (prdata), .pready (pready),
    .cpu_valid (cpu_valid), .cpu_instr (cpu_instr), .cpu_trap (cpu_trap),
    .syscall (syscall), .cpu_addr (cpu_addr), .force_trap (force_trap),
    .fw_startup_done (fw_startup_done), .app_mode (app_mode),
    .gpio_in (gpio_in), .gpio_out (gpio_out),
    .led_r (led_r), .led_g (led_g), .led_b (led_b)
  );

  always #2 clk = ~clk;

  //--------------------------------------------------------------------
  // Reporting
  //--------------------------------------------------------------------

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic end_run();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    timeouts++;
    $display("Timeout: %s", what);
    end_run();
  endtask

  //--------------------------------------------------------------------
  // Stimulus helpers
  //--------------------------------------------------------------------

  function automatic bit expected_app_mode();
    return model_fw_done && !syscall;
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    reset_n   = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    cpu_valid = 1'b0;
    cpu_instr = 1'b0;
    cpu_trap  = 1'b0;
    syscall   = 1'b0;
    repeat (3) @(negedge clk);
    reset_n = 1'b1;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = '0;
    end
    shadow[`TK1_ADDR_LED]      = 32'h6;
    shadow[`TK1_ADDR_APP_SIZE] = APP_SIZE_INIT;
    model_trap    = 1'b0;
    model_fw_done = 1'b0;
  endtask

  task automatic apb_transfer(input bit write, input reg_addr_t addr, input word_t wdata,
                              output word_t rdata);
    int waited;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    waited = 0;
    while (!pready && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!pready) begin
      timed_out("APB slave never raised pready");
    end else begin
      rdata = prdata;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input word_t data);
    word_t ignored;
    apb_transfer(1'b1, addr, data, ignored);
    shadow[addr] = reg_after_write(addr, shadow[addr], data, expected_app_mode(),
                                   shadow[`TK1_ADDR_MON_CTRL][0]);
  endtask

  task automatic read_check(input reg_addr_t addr);
    word_t rdata;
    apb_transfer(1'b0, addr, 32'h0, rdata);
    check_value($sformatf("prdata@%02h", addr), rdata,
                reg_read_value(addr, shadow[addr], gpio_in));
  endtask

  // One valid CPU cycle with flags checked before and after the edge that ends it
  task automatic cpu_access(input word_t addr, input bit instr);
    bit exp_trap;
    bit exp_done;
    @(negedge clk);
    exp_trap = model_trap || map_violation(addr) ||
               (instr && exec_violation(addr, expected_app_mode(),
                                        shadow[`TK1_ADDR_MON_CTRL][0],
                                        shadow[`TK1_ADDR_MON_FIRST],
                                        shadow[`TK1_ADDR_MON_LAST]));
    exp_done = model_fw_done || (instr && (addr > `TK1_FW_ROM_LAST));
    cpu_valid = 1'b1;
    cpu_instr = instr;
    cpu_addr  = addr;
    #1;
    check_value("force_trap", word_t'(force_trap), word_t'(model_trap));
    @(negedge clk);
    cpu_valid     = 1'b0;
    cpu_instr     = 1'b0;
    model_trap    = exp_trap;
    model_fw_done = exp_done;
    #1;
    check_value("force_trap", word_t'(force_trap), word_t'(model_trap));
    check_value("fw_startup_done", word_t'(fw_startup_done), word_t'(model_fw_done));
    check_value("app_mode", word_t'(app_mode), word_t'(expected_app_mode()));
  endtask

  function automatic word_t random_cpu_addr();
    word_t      addr;
    logic [1:0] pick;
    addr = $urandom;
    pick = 2'($urandom_range(0, 3));
    case ($urandom_range(0, 3))
      0:       addr = addr & 32'h4001_ffff;
      1:       addr = addr & 32'h4000_3fff;
      2:       addr = {2'b11, MMIO_IDS[pick], addr[23:0] & 24'h000fff};
      default: addr = addr;
    endcase
    return addr;
  endfunction

  function automatic reg_addr_t pick_reg(int unsigned idx);
    case (idx)
      0:       return `TK1_ADDR_LED;
      1:       return `TK1_ADDR_GPIO;
      2:       return `TK1_ADDR_APP_START;
      3:       return `TK1_ADDR_APP_SIZE;
      default: return reg_addr_t'(`TK1_ADDR_CDI_FIRST + idx - 4);
    endcase
  endfunction

  task automatic verify_leds();
    check_value("led_rgb", {29'h0, led_r, led_g, led_b}, shadow[`TK1_ADDR_LED]);
  endtask

  task automatic trap_blink_test();
    logic first_r;
    int   waited;
    @(negedge clk);
    cpu_trap = 1'b1;
    #1;
    first_r = led_r;
    waited  = 0;
    while (led_r == first_r && waited < 40) begin
      check_value("led_g", word_t'(led_g), 32'h0);
      check_value("led_b", word_t'(led_b), 32'h0);
      @(negedge clk);
      #1;
      waited++;
    end
    if (led_r == first_r) begin
      errors++;
      $display("led_r did not toggle within 40 cycles while cpu_trap was high");
    end
    @(negedge clk);
    cpu_trap = 1'b0;
    #1;
    verify_leds();
  endtask

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------

  initial begin
    reset_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    cpu_valid = 1'b0;
    cpu_instr = 1'b0;
    cpu_trap = 1'b0;
    syscall = 1'b0;
    cpu_addr = '0;
    gpio_in = 2'b00;
    checks = 0;
    errors = 0;
    timeouts = 0;
    void'($urandom(44741));
    apply_reset();

    // Reset values and identification
    #1;
    check_value("force_trap", word_t'(force_trap), 32'h0);
    check_value("fw_startup_done", word_t'(fw_startup_done), 32'h0);
    check_value("app_mode", word_t'(app_mode), 32'h0);
    read_check(`TK1_ADDR_NAME0);
    read_check(`TK1_ADDR_NAME1);
    read_check(`TK1_ADDR_VERSION);
    read_check(`TK1_ADDR_LED);
    read_check(`TK1_ADDR_APP_SIZE);
    read_check(8'h03);

    // Firmware mode register traffic
    for (int i = 0; i < 40; i++) begin
      write_reg(pick_reg($urandom_range(0, 11)), $urandom);
      read_check(pick_reg($urandom_range(0, 11)));
      check_value("gpio_out", word_t'(gpio_out), word_t'(shadow[`TK1_ADDR_GPIO][3:2]));
      verify_leds();
    end
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      gpio_in = 2'($urandom_range(0, 3));
      repeat (3) @(negedge clk);
      read_check(`TK1_ADDR_GPIO);
    end

    // Application mode protection and syscall
    cpu_access(32'h4000_0100, 1'b1);
    for (int i = 0; i < 2; i++) begin
      write_reg(`TK1_ADDR_APP_START, $urandom);
      write_reg(`TK1_ADDR_APP_SIZE, $urandom);
      write_reg(reg_addr_t'(`TK1_ADDR_CDI_FIRST + 3), $urandom);
      write_reg(`TK1_ADDR_LED, $urandom);
      read_check(`TK1_ADDR_APP_START);
      read_check(`TK1_ADDR_APP_SIZE);
      read_check(reg_addr_t'(`TK1_ADDR_CDI_FIRST + 3));
      read_check(`TK1_ADDR_LED);
      verify_leds();
      @(negedge clk);
      syscall = (i == 0);
      #1;
      check_value("app_mode", word_t'(app_mode), word_t'(expected_app_mode()));
    end

    // Address map violations with a reset before each random access
    for (int i = 0; i < 48; i++) begin
      apply_reset();
      cpu_access(random_cpu_addr(), 1'($urandom_range(0, 1)));
      cpu_access(32'h0000_0100, 1'b0);
    end

    // Locked execution window
    apply_reset();
    write_reg(`TK1_ADDR_MON_FIRST, 32'h4000_1000);
    write_reg(`TK1_ADDR_MON_LAST, 32'h4000_1fff);
    write_reg(`TK1_ADDR_MON_CTRL, 32'h1);
    write_reg(`TK1_ADDR_MON_FIRST, 32'h4000_0000);
    write_reg(`TK1_ADDR_MON_LAST, 32'h4000_ffff);
    read_check(`TK1_ADDR_MON_FIRST);
    cpu_access(32'h4000_0800, 1'b1);
    cpu_access(32'h4000_1800, 1'b0);
    cpu_access(32'h4000_1800, 1'b1);

    // All LEDs on so the trap override shows on every color
    write_reg(`TK1_ADDR_LED, 32'h7);
    trap_blink_test();
    end_run();
  end

endmodule

`default_nettype wire

/* design/tk1.sv */
// Top level of the tk1 information, debug and control core with plain APB and CPU ports
`timescale 1ns/1ps
`default_nettype none

`include "tk1_config.svh"

module tk1 #(
  parameter tk1_pkg::word_t app_size_init = 32'h0,
  parameter int             blink_width   = `TK1_BLINK_WIDTH_DEFAULT
) (
  input  wire                clk,
  input  wire                reset_n,

  // APB slave
  input  wire                psel,
  input  wire                penable,
  input  wire                pwrite,
  input  tk1_pkg::reg_addr_t paddr,
  input  tk1_pkg::word_t     pwdata,
  output tk1_pkg::word_t     prdata,
  output logic               pready,

  // CPU side
  input  wire                cpu_valid,
  input  wire                cpu_instr,
  input  wire                cpu_trap,
  input  wire                syscall,
  input  tk1_pkg::word_t     cpu_addr,
  output logic               force_trap,
  output logic               fw_startup_done,
  output logic               app_mode,

  // GPIO and LEDs
  input  wire  [1:0]         gpio_in,
  output logic [1:0]         gpio_out,
  output logic               led_r,
  output logic               led_g,
  output logic               led_b
);
  import tk1_pkg::*;

  exec_window_t exec_window;
  led_t         led_state;

  tk1_reg_if reg_bus ();

  tk1_apb_slave apb0 (
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .bus     (reg_bus)
  );

  tk1_regs #(
    .app_size_init (app_size_init)
  ) regs0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .regs        (reg_bus),
    .app_mode    (app_mode),
    .gpio_in     (gpio_in),
    .gpio_out    (gpio_out),
    .led_state   (led_state),
    .exec_window (exec_window)
  );

  tk1_sec_monitor mon0 (
    .clk             (clk),
    .reset_n         (reset_n),
    .cpu_valid       (cpu_valid),
    .cpu_instr       (cpu_instr),
    .cpu_addr        (cpu_addr),
    .syscall         (syscall),
    .exec_window     (exec_window),
    .force_trap      (force_trap),
    .fw_startup_done (fw_startup_done),
    .app_mode        (app_mode)
  );

  tk1_led_blink #(
    .blink_width (blink_width)
  ) led0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .cpu_trap  (cpu_trap),
    .led_state (led_state),
    .led_r     (led_r),
    .led_g     (led_g),
    .led_b     (led_b)
  );

endmodule

`default_nettype wire

/* design/tk1_apb_slave.sv */
// APB slave front end, turns each access cycle into one register read or write
`timescale 1ns/1ps
`default_nettype none

module tk1_apb_slave (
  input  wire               psel,
  input  wire               penable,
  input  wire               pwrite,
  input  tk1_pkg::reg_addr_t paddr,
  input  tk1_pkg::word_t    pwdata,
  output tk1_pkg::word_t    prdata,
  output logic              pready,
  tk1_reg_if.bus            bus
);

  logic access;

  //--------------------------------------------------------------------
  // Access phase decode
  //--------------------------------------------------------------------

  // Access cycle is the second cycle of a transfer
  assign access = psel & penable;

  assign bus.wr_en = access & pwrite;
  assign bus.rd_en = access & ~pwrite;
  assign bus.addr  = paddr;
  assign bus.wdata = pwdata;

  // Read data comes straight from the register mux
  assign prdata = bus.rdata;

  // No wait states, ready as soon as the slave is selected
  assign pready = psel;

  //--------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------

  // The setup cycle must precede every access cycle, so pready is already
  // high when penable rises
  a_ready_on_enable : assert property (@(posedge penable) pready)
    else $error("pready low while penable high");

endmodule

`default_nettype wire

/* design/tk1_config.svh */
// Register map, identification words and memory map limits, included by RTL and bench
`ifndef TK1_CONFIG_SVH
`define TK1_CONFIG_SVH

// Register word addresses
`define TK1_ADDR_NAME0       8'h00
`define TK1_ADDR_NAME1       8'h01
`define TK1_ADDR_VERSION     8'h02
`define TK1_ADDR_LED         8'h09
`define TK1_ADDR_GPIO        8'h0a
`define TK1_ADDR_APP_START   8'h0c
`define TK1_ADDR_APP_SIZE    8'h0d
`define TK1_ADDR_CDI_FIRST   8'h20
`define TK1_ADDR_CDI_LAST    8'h27
`define TK1_ADDR_MON_CTRL    8'h60
`define TK1_ADDR_MON_FIRST   8'h61
`define TK1_ADDR_MON_LAST    8'h62

// Identification words, "tk1 " and "mkdf" in ASCII
`define TK1_NAME0            32'h746b3120
`define TK1_NAME1            32'h6d6b6466
`define TK1_VERSION          32'h00000006

// Memory map limits
`define TK1_FW_ROM_LAST      32'h00001fff
`define TK1_FW_RAM_FIRST     32'hd0000000
`define TK1_FW_RAM_LAST      32'hd0000fff
`define TK1_ROM_ADDR_BITS    13
`define TK1_RAM_ADDR_BITS    17

// MMIO block numbers (address bits 29:24)
`define TK1_MMIO_TRNG_ID     6'h00
`define TK1_MMIO_TIMER_ID    6'h01
`define TK1_MMIO_UDS_ID      6'h02
`define TK1_MMIO_UART_ID     6'h03
`define TK1_MMIO_TOUCH_ID    6'h04
`define TK1_MMIO_FW_RAM_ID   6'h10
`define TK1_MMIO_SYSCALL_ID  6'h21
`define TK1_MMIO_TK1_ID      6'h3f

// Valid offset bits per MMIO block
`define TK1_MMIO_TRNG_BITS     10
`define TK1_MMIO_TIMER_BITS    10
`define TK1_MMIO_UDS_BITS      5
`define TK1_MMIO_UART_BITS     10
`define TK1_MMIO_TOUCH_BITS    10
`define TK1_MMIO_FW_RAM_BITS   12
`define TK1_MMIO_SYSCALL_BITS  2
`define TK1_MMIO_TK1_BITS      10

// Trap blink counter width
`define TK1_BLINK_WIDTH_DEFAULT 24

`endif

/* design/tk1_led_blink.sv */
// LED output stage, blinks red while the CPU is trapped and shows the LED register otherwise
`timescale 1ns/1ps
`default_nettype none

`include "tk1_config.svh"

module tk1_led_blink #(
  parameter int blink_width = `TK1_BLINK_WIDTH_DEFAULT
) (
  input  wire           clk,
  input  wire           reset_n,
  input  wire           cpu_trap,
  input  tk1_pkg::led_t led_state,
  output logic          led_r,
  output logic          led_g,
  output logic          led_b
);

  logic [blink_width-1:0] cnt_q;
  logic                   blink_q;

  // Free-running counter, blink bit toggles on each wrap
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      cnt_q   <= '0;
      blink_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
      if (&cnt_q) begin
        blink_q <= ~blink_q;
      end
    end
  end

  // Trap overrides the register, red only
  assign led_r = cpu_trap ? blink_q : led_state.r;
  assign led_g = cpu_trap ? 1'b0 : led_state.g;
  assign led_b = cpu_trap ? 1'b0 : led_state.b;

endmodule

`default_nettype wire

/* design/tk1_pkg.sv */
// Shared types of the tk1 core, imported by the RTL modules and the bench
`default_nettype none

package tk1_pkg;

  //--------------------------------------------------------------------
  // Bus types
  //--------------------------------------------------------------------

  // Register word address on the APB side
  typedef logic [7:0] reg_addr_t;

  // Data word, also used for CPU addresses
  typedef logic [31:0] word_t;

  //--------------------------------------------------------------------
  // Register contents
  //--------------------------------------------------------------------

  // LED field, red in bit 2 down to blue in bit 0
  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } led_t;

  // Execution-forbidden window, inclusive bounds
  typedef struct packed {
    logic  en;
    word_t first;
    word_t last;
  } exec_window_t;

endpackage

`default_nettype wire

/* design/tk1_reg_if.sv */
// Single-cycle register access bus between the APB slave and the register file
`timescale 1ns/1ps
`default_nettype none

interface tk1_reg_if;
  import tk1_pkg::*;

  // Write strobe, one cycle per APB write
  logic      wr_en;
  // High during the access cycle of a read
  logic      rd_en;
  reg_addr_t addr;
  word_t     wdata;
  word_t     rdata;

  // Bus side, owned by the APB slave
  modport bus (
    output wr_en,
    output rd_en,
    output addr,
    output wdata,
    input  rdata
  );

  // Register side
  modport regs (
    input  wr_en,
    input  rd_en,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* design/tk1_regs.sv */
// Register file of the tk1 core with its write rules and the read multiplexer
`timescale 1ns/1ps
`default_nettype none

`include "tk1_config.svh"

module tk1_regs #(
  parameter tk1_pkg::word_t app_size_init = 32'h0
) (
  input  wire                    clk,
  input  wire                    reset_n,
  tk1_reg_if.regs                regs,
  input  wire                    app_mode,
  input  wire  [1:0]             gpio_in,
  output logic [1:0]             gpio_out,
  output tk1_pkg::led_t          led_state,
  output tk1_pkg::exec_window_t  exec_window
);
  import tk1_pkg::*;

  led_t         led_q;
  logic [1:0]   gpio_meta_q;
  logic [1:0]   gpio_sync_q;
  logic [1:0]   gpio_out_q;
  word_t        app_start_q;
  word_t        app_size_q;
  word_t        cdi_q [0:7];
  exec_window_t win_q;

  logic         led_we;
  logic         gpio_we;
  logic         app_start_we;
  logic         app_size_we;
  logic         cdi_we;
  logic         mon_ctrl_we;
  logic         mon_first_we;
  logic         mon_last_we;
  logic         in_cdi;
  word_t        rd_mux;

  //--------------------------------------------------------------------
  // Write decode
  //--------------------------------------------------------------------

  assign in_cdi = (regs.addr >= `TK1_ADDR_CDI_FIRST) &&
                  (regs.addr <= `TK1_ADDR_CDI_LAST);

  always_comb begin
    led_we       = 1'b0;
    gpio_we      = 1'b0;
    app_start_we = 1'b0;
    app_size_we  = 1'b0;
    cdi_we       = 1'b0;
    mon_ctrl_we  = 1'b0;
    mon_first_we = 1'b0;
    mon_last_we  = 1'b0;

    if (regs.wr_en) begin
      // LED and GPIO stay writable from the application
      led_we  = (regs.addr == `TK1_ADDR_LED);
      gpio_we = (regs.addr == `TK1_ADDR_GPIO);

      // Firmware only
      app_start_we = (regs.addr == `TK1_ADDR_APP_START) && !app_mode;
      app_size_we  = (regs.addr == `TK1_ADDR_APP_SIZE) && !app_mode;
      cdi_we       = in_cdi && !app_mode;

      // Window bounds lock once the monitor is enabled
      mon_ctrl_we  = (regs.addr == `TK1_ADDR_MON_CTRL);
      mon_first_we = (regs.addr == `TK1_ADDR_MON_FIRST) && !win_q.en;
      mon_last_we  = (regs.addr == `TK1_ADDR_MON_LAST) && !win_q.en;
    end
  end

  //--------------------------------------------------------------------
  // Register state
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      led_q       <= 3'b110;
      gpio_meta_q <= 2'b00;
      gpio_sync_q <= 2'b00;
      gpio_out_q  <= 2'b00;
      app_start_q <= '0;
      app_size_q  <= app_size_init;
      win_q       <= '0;
      for (int i = 0; i < 8; i++) begin
        cdi_q[i] <= '0;
      end
    end else begin
      // Two-stage synchronizer on the GPIO inputs
      gpio_meta_q <= gpio_in;
      gpio_sync_q <= gpio_meta_q;

      if (led_we) begin
        led_q <= regs.wdata[2:0];
      end
      if (gpio_we) begin
        gpio_out_q <= regs.wdata[3:2];
      end
      if (app_start_we) begin
        app_start_q <= regs.wdata;
      end
      if (app_size_we) begin
        app_size_q <= regs.wdata;
      end
      if (cdi_we) begin
        cdi_q[regs.addr[2:0]] <= regs.wdata;
      end

      // Sticky enable, any write sets it
      if (mon_ctrl_we) begin
        win_q.en <= 1'b1;
      end
      if (mon_first_we) begin
        win_q.first <= regs.wdata;
      end
      if (mon_last_we) begin
        win_q.last <= regs.wdata;
      end
    end
  end

  assign gpio_out    = gpio_out_q;
  assign led_state   = led_q;
  assign exec_window = win_q;

  //--------------------------------------------------------------------
  // Read multiplexer
  //--------------------------------------------------------------------

  always_comb begin
    rd_mux = '0;
    case (regs.addr)
      `TK1_ADDR_NAME0:     rd_mux = `TK1_NAME0;
      `TK1_ADDR_NAME1:     rd_mux = `TK1_NAME1;
      `TK1_ADDR_VERSION:   rd_mux = `TK1_VERSION;
      `TK1_ADDR_LED:       rd_mux = {29'h0, led_q};
      `TK1_ADDR_GPIO:      rd_mux = {28'h0, gpio_out_q, gpio_sync_q};
      `TK1_ADDR_APP_START: rd_mux = app_start_q;
      `TK1_ADDR_APP_SIZE:  rd_mux = app_size_q;
      default: begin
        if (in_cdi) begin
          rd_mux = cdi_q[regs.addr[2:0]];
        end
      end
    endcase
  end

  // Zero outside read access cycles
  assign regs.rdata = regs.rd_en ? rd_mux : '0;

  //--------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------

  a_window_en_sticky : assert property (@(posedge clk) (win_q.en && reset_n) |=> win_q.en)
    else $error("exec window enable cleared without reset");

endmodule

`default_nettype wire

/* design/tk1_sec_monitor.sv */
// Security monitor, tracks privilege and raises a sticky trap on illegal CPU accesses
`timescale 1ns/1ps
`default_nettype none

`include "tk1_config.svh"

module tk1_sec_monitor (
  input  wire                   clk,
  input  wire                   reset_n,
  input  wire                   cpu_valid,
  input  wire                   cpu_instr,
  input  tk1_pkg::word_t        cpu_addr,
  input  wire                   syscall,
  input  tk1_pkg::exec_window_t exec_window,
  output logic                  force_trap,
  output logic                  fw_startup_done,
  output logic                  app_mode
);
  import tk1_pkg::*;

  // Region codes in address bits 31:30
  localparam logic [1:0] REGION_ROM  = 2'b00;
  localparam logic [1:0] REGION_RAM  = 2'b01;
  localparam logic [1:0] REGION_RSVD = 2'b10;
  localparam logic [1:0] REGION_MMIO = 2'b11;

  logic       fw_done_q;
  logic       trap_q;
  logic       map_bad;
  logic       mmio_bad;
  logic       exec_bad;
  logic       trap_set;
  logic       fw_done_set;
  logic [1:0] region;

  // True when the block offset uses bits above the block size
  function automatic logic over_size(word_t addr, int unsigned bits);
    logic [23:0] offset;
    offset = addr[23:0];
    return (offset >> bits) != 24'h0;
  endfunction

  //--------------------------------------------------------------------
  // Memory map check
  //--------------------------------------------------------------------

  assign region = cpu_addr[31:30];

  always_comb begin
    case (cpu_addr[29:24])
      `TK1_MMIO_TRNG_ID:    mmio_bad = over_size(cpu_addr, `TK1_MMIO_TRNG_BITS);
      `TK1_MMIO_TIMER_ID:   mmio_bad = over_size(cpu_addr, `TK1_MMIO_TIMER_BITS);
      `TK1_MMIO_UDS_ID:     mmio_bad = over_size(cpu_addr, `TK1_MMIO_UDS_BITS);
      `TK1_MMIO_UART_ID:    mmio_bad = over_size(cpu_addr, `TK1_MMIO_UART_BITS);
      `TK1_MMIO_TOUCH_ID:   mmio_bad = over_size(cpu_addr, `TK1_MMIO_TOUCH_BITS);
      `TK1_MMIO_FW_RAM_ID:  mmio_bad = over_size(cpu_addr, `TK1_MMIO_FW_RAM_BITS);
      `TK1_MMIO_SYSCALL_ID: mmio_bad = over_size(cpu_addr, `TK1_MMIO_SYSCALL_BITS);
      `TK1_MMIO_TK1_ID:     mmio_bad = over_size(cpu_addr, `TK1_MMIO_TK1_BITS);
      // Unassigned block numbers
      default:              mmio_bad = 1'b1;
    endcase
  end

  always_comb begin
    case (region)
      REGION_ROM:  map_bad = |cpu_addr[29:`TK1_ROM_ADDR_BITS];
      REGION_RAM:  map_bad = |cpu_addr[29:`TK1_RAM_ADDR_BITS];
      REGION_RSVD: map_bad = 1'b1;
      REGION_MMIO: map_bad = mmio_bad;
      default:     map_bad = 1'b1;
    endcase
  end

  //--------------------------------------------------------------------
  // Instruction fetch checks
  //--------------------------------------------------------------------

  always_comb begin
    exec_bad = 1'b0;
    if ((cpu_addr >= `TK1_FW_RAM_FIRST) && (cpu_addr <= `TK1_FW_RAM_LAST)) begin
      exec_bad = 1'b1;
    end
    // ROM starts at address zero, so only the upper bound matters
    if (app_mode && (cpu_addr <= `TK1_FW_ROM_LAST)) begin
      exec_bad = 1'b1;
    end
    if (exec_window.en && (cpu_addr >= exec_window.first) &&
        (cpu_addr <= exec_window.last)) begin
      exec_bad = 1'b1;
    end
  end

  assign trap_set    = cpu_valid & (map_bad | (cpu_instr & exec_bad));
  assign fw_done_set = cpu_valid & cpu_instr & (cpu_addr > `TK1_FW_ROM_LAST);

  //--------------------------------------------------------------------
  // Sticky flags
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      fw_done_q <= 1'b0;
      trap_q    <= 1'b0;
    end else begin
      if (fw_done_set) begin
        fw_done_q <= 1'b1;
      end
      if (trap_set) begin
        trap_q <= 1'b1;
      end
    end
  end

  assign force_trap      = trap_q;
  assign fw_startup_done = fw_done_q;
  // Syscall lends firmware rights back while it is high
  assign app_mode        = fw_done_q & ~syscall;

  a_trap_sticky : assert property (@(posedge clk) (trap_q && reset_n) |=> trap_q)
    else $error("force_trap cleared without reset");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the tk1 testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_tk1 \
  -f tk1.f \
  -o tb_tk1

./obj_dir/tb_tk1 | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "tk1 simulation reported failure"
  exit 1
fi

echo "tk1 simulation finished without failure"

/* tk1.f */
+incdir+design
+incdir+bench
design/tk1_pkg.sv
design/tk1_reg_if.sv
design/tk1_apb_slave.sv
design/tk1_regs.sv
design/tk1_sec_monitor.sv
design/tk1_led_blink.sv
design/tk1.sv
bench/tb_tk1.sv
